// ==== flist.f ====
hdl/trace_pkg.sv
hdl/record_fifo.sv
hdl/commit_tracker.sv
hdl/store_tracker.sv
hdl/event_arbiter.sv
hdl/commit_trace_unit.sv
dv/commit_trace_properties.sv
dv/tb_commit_trace.sv

// ==== Makefile ====
# Verilator build and run for the commit trace unit testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_commit_trace
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run clean

all: run

# compile the testbench and the DUT into a simulation binary
build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# a failing run ends in $$fatal, so the exit status carries the result
run: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_commit_trace.sv ====
// commit trace testbench, random writeback traffic checked against a reference model
`timescale 1ns/100ps

module tb_commit_trace;

  localparam int xlen = trace_pkg::xlen;
  localparam int fifo_depth = 4;
  localparam logic [47:0] mmio_page = 48'h200;
  localparam logic [6:0] trap_opcode = 7'h6b;
  localparam int reset_cycles = 10;
  localparam int num_stim = 400;
  // random phase, drain allowance and the overflow phase
  localparam int stim_cycles = reset_cycles + num_stim + 64 + 12 + fifo_depth + 4;
  localparam int timeout_cycles = 3 * stim_cycles;
  // pc, inst, rd enable, rd index, data, addr, skip
  localparam int commit_w = xlen + 32 + 1 + 5 + xlen + xlen + 1;
  // addr, data, mask
  localparam int store_w = xlen + xlen + 8;

  logic                    clock;
  logic                    reset;
  logic                    wb_commit;
  logic [xlen-1:0]         wb_pc;
  logic [31:0]             wb_inst;
  logic                    wb_rd_ena;
  logic [4:0]              wb_rd_addr;
  logic [xlen-1:0]         wb_rd_data;
  logic                    wb_skip;
  logic                    wb_store_ena;
  logic [xlen-1:0]         wb_store_addr;
  logic [xlen-1:0]         wb_store_data;
  logic [7:0]              wb_store_mask;
  logic                    event_ack;
  logic                    event_req;
  trace_pkg::event_kind_e  event_kind;
  logic [xlen-1:0]         event_pc;
  logic [31:0]             event_inst;
  logic                    event_rd_ena;
  logic [4:0]              event_rd_addr;
  logic [xlen-1:0]         event_data;
  logic [xlen-1:0]         event_addr;
  logic [7:0]              event_mask;
  logic                    event_skip;
  logic                    overflow;

  // reference model state
  logic [xlen-1:0]     model_cycle;
  logic [xlen-1:0]     model_instr;
  logic [commit_w-1:0] commit_q[$];
  logic [commit_w-1:0] trap_q[$];
  logic [store_w-1:0]  store_q[$];

  int    seed = 32'h7f8e;
  int    cycle_ctr = 0;
  int    n_commit = 0;
  int    n_trap = 0;
  int    n_store = 0;
  logic  ack_hold;
  string test_name;

  commit_trace_unit #(
    .fifo_depth (fifo_depth),
    .mmio_page  (mmio_page)
  ) u_dut (
    .clock         (clock),
    .reset         (reset),
    .wb_commit     (wb_commit),
    .wb_pc         (wb_pc),
    .wb_inst       (wb_inst),
    .wb_rd_ena     (wb_rd_ena),
    .wb_rd_addr    (wb_rd_addr),
    .wb_rd_data    (wb_rd_data),
    .wb_skip       (wb_skip),
    .wb_store_ena  (wb_store_ena),
    .wb_store_addr (wb_store_addr),
    .wb_store_data (wb_store_data),
    .wb_store_mask (wb_store_mask),
    .event_ack     (event_ack),
    .event_req     (event_req),
    .event_kind    (event_kind),
    .event_pc      (event_pc),
    .event_inst    (event_inst),
    .event_rd_ena  (event_rd_ena),
    .event_rd_addr (event_rd_addr),
    .event_data    (event_data),
    .event_addr    (event_addr),
    .event_mask    (event_mask),
    .event_skip    (event_skip),
    .overflow      (overflow)
  );

  bind commit_trace_unit commit_trace_properties u_props (
    .clock         (clock),
    .reset         (reset),
    .event_req     (event_req),
    .event_ack     (event_ack),
    .event_kind    (event_kind),
    .event_pc      (event_pc),
    .event_inst    (event_inst),
    .event_rd_ena  (event_rd_ena),
    .event_rd_addr (event_rd_addr),
    .event_data    (event_data),
    .event_addr    (event_addr),
    .event_mask    (event_mask),
    .event_skip    (event_skip)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string field, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %s %s expected %h actual %h", test_name, field, expected,
                          actual));
    end
  endtask

  always @(posedge clock) begin
    cycle_ctr = cycle_ctr + 1;
    if (u_dut.u_props.fail_count != 0) begin
      abort_run("handshake assertion failed on the event port");
    end else if (cycle_ctr > timeout_cycles) begin
      abort_run($sformatf("timeout, run did not finish within %0d cycles", timeout_cycles));
    end
  end

  // model samples the driven inputs at the same edge as the DUT
  always @(posedge clock) begin
    if (reset) begin
      model_cycle = '0;
      model_instr = '0;
    end else begin
      if (wb_commit) begin
        model_instr = model_instr + 1'b1;
        if (wb_inst[6:0] == trap_opcode) begin
          trap_q.push_back({wb_pc, wb_inst, wb_rd_ena, wb_rd_addr, model_instr, model_cycle,
                            wb_skip});
        end else begin
          commit_q.push_back({wb_pc, wb_inst, wb_rd_ena, wb_rd_addr, wb_rd_data,
                              {xlen{1'b0}}, wb_skip});
        end
        if (wb_store_ena && wb_store_addr[xlen-1:16] != mmio_page) begin
          store_q.push_back({wb_store_addr, wb_store_data, wb_store_mask});
        end
      end
      model_cycle = model_cycle + 1'b1;
    end
  end

  task automatic drive_idle();
    wb_commit     = 1'b0;
    wb_pc         = '0;
    wb_inst       = '0;
    wb_rd_ena     = 1'b0;
    wb_rd_addr    = '0;
    wb_rd_data    = '0;
    wb_skip       = 1'b0;
    wb_store_ena  = 1'b0;
    wb_store_addr = '0;
    wb_store_data = '0;
    wb_store_mask = '0;
  endtask

  // commits only when the model shows room, so nothing is lost here
  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] a;
    logic        room_commit;
    logic        room_store;
    r = $random(seed);
    a = $random(seed);
    room_commit   = (commit_q.size() + trap_q.size()) < fifo_depth;
    room_store    = store_q.size() < fifo_depth;
    wb_commit     = room_commit && (r[1:0] != 2'b00);
    wb_pc         = {$random(seed), $random(seed)};
    wb_inst       = (r[4:2] == 3'd0) ? {a[31:7], trap_opcode} : a;
    wb_skip       = r[5];
    wb_rd_ena     = r[6];
    wb_rd_addr    = r[11:7];
    wb_rd_data    = {$random(seed), $random(seed)};
    wb_store_ena  = r[12] && (room_store || !wb_commit);
    wb_store_addr = (r[14:13] == 2'd0) ? {mmio_page, a[15:0]} : {$random(seed), $random(seed)};
    wb_store_data = {$random(seed), $random(seed)};
    wb_store_mask = r[23:16];
  endtask

  task automatic compare_instr(input logic [commit_w-1:0] rec, input logic is_trap);
    logic [xlen-1:0] e_pc;
    logic [31:0]     e_inst;
    logic            e_rd_ena;
    logic [4:0]      e_rd_addr;
    logic [xlen-1:0] e_data;
    logic [xlen-1:0] e_addr;
    logic            e_skip;
    {e_pc, e_inst, e_rd_ena, e_rd_addr, e_data, e_addr, e_skip} = rec;
    check_value("pc", e_pc, event_pc);
    check_value("inst", 64'(e_inst), 64'(event_inst));
    check_value("rd_ena", 64'(e_rd_ena), 64'(event_rd_ena));
    check_value("rd_addr", 64'(e_rd_addr), 64'(event_rd_addr));
    check_value("data", e_data, event_data);
    check_value("skip", 64'(e_skip), 64'(event_skip));
    // trap carries the cycle stamp in addr
    if (is_trap) begin
      check_value("trap cycle", e_addr, event_addr);
    end
  endtask

  task automatic check_event();
    logic [store_w-1:0] srec;
    logic [xlen-1:0]    e_addr;
    logic [xlen-1:0]    e_data;
    logic [7:0]         e_mask;
    if (event_kind == trace_pkg::kind_commit && commit_q.size() != 0) begin
      n_commit++;
      compare_instr(commit_q.pop_front(), 1'b0);
    end else if (event_kind == trace_pkg::kind_trap && trap_q.size() != 0) begin
      n_trap++;
      compare_instr(trap_q.pop_front(), 1'b1);
    end else if (event_kind == trace_pkg::kind_store && store_q.size() != 0) begin
      n_store++;
      srec = store_q.pop_front();
      {e_addr, e_data, e_mask} = srec;
      check_value("store addr", e_addr, event_addr);
      check_value("store data", e_data, event_data);
      check_value("store mask", 64'(e_mask), 64'(event_mask));
      check_value("store pc", '0, event_pc);
      check_value("store other fields", '0,
                  64'({event_inst, event_rd_ena, event_rd_addr, event_skip}));
    end else begin
      abort_run($sformatf("event of kind %0d arrived with none of that kind pending",
                          event_kind));
    end
  endtask

  // consumer samples at the falling edge, drives ack after the rising edge
  initial begin : consumer
    int delay;
    forever begin
      @(negedge clock);
      if (event_req && !ack_hold) begin
        check_event();
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clock);
        @(posedge clock);
        #1;
        event_ack = 1'b1;
        do begin
          @(negedge clock);
        end while (event_req);
        @(posedge clock);
        #1;
        event_ack = 1'b0;
      end
    end
  end

  initial begin
    test_name = "reset";
    reset     = 1'b1;
    event_ack = 1'b0;
    ack_hold  = 1'b0;
    drive_idle();
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;

    test_name = "random_mix";
    repeat (num_stim) begin
      drive_random();
      @(posedge clock);
      #1;
    end
    drive_idle();

    test_name = "drain";
    while (commit_q.size() + trap_q.size() + store_q.size() != 0) begin
      @(posedge clock);
    end
    // a duplicated event would show up in this window
    repeat (12) @(posedge clock);
    #1;
    if (n_commit == 0 || n_trap == 0 || n_store == 0) begin
      abort_run("random traffic did not produce every event kind");
    end
    check_value("overflow before hold", '0, 64'(overflow));

    // consumer stalls, queue must overflow
    test_name = "overflow";
    ack_hold = 1'b1;
    repeat (fifo_depth + 3) begin
      wb_commit = 1'b1;
      wb_inst   = 32'h0000_0013;
      @(posedge clock);
      #1;
    end
    drive_idle();
    @(posedge clock);
    #1;
    check_value("overflow after hold", 64'd1, 64'(overflow));

    if (u_dut.u_props.fail_count != 0) begin
      abort_run("handshake assertions failed during the run");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== dv/commit_trace_properties.sv ====
// commit trace properties, four-phase handshake rules on the event port
`timescale 1ns/100ps

module commit_trace_properties (
  input logic                             clock,
  input logic                             reset,
  input logic                             event_req,
  input logic                             event_ack,
  input trace_pkg::event_kind_e           event_kind,
  input logic [trace_pkg::xlen-1:0]       event_pc,
  input logic [trace_pkg::inst_w-1:0]     event_inst,
  input logic                             event_rd_ena,
  input logic [trace_pkg::reg_addr_w-1:0] event_rd_addr,
  input logic [trace_pkg::xlen-1:0]       event_data,
  input logic [trace_pkg::xlen-1:0]       event_addr,
  input logic [trace_pkg::mask_w-1:0]     event_mask,
  input logic                             event_skip
);

  localparam int fields_w = 2 + 3 * trace_pkg::xlen + trace_pkg::inst_w +
                            trace_pkg::reg_addr_w + trace_pkg::mask_w + 2;

  int                fail_count = 0;
  logic [fields_w-1:0] fields;

  assign fields = {event_kind, event_pc, event_inst, event_rd_ena, event_rd_addr,
                   event_data, event_addr, event_mask, event_skip};

  // request holds until acknowledged
  req_held: assert property (@(posedge clock) disable iff (reset)
    event_req && !event_ack |=> event_req)
    else begin
      $error("event_req fell before event_ack rose");
      fail_count = fail_count + 1;
    end

  fields_stable: assert property (@(posedge clock) disable iff (reset)
    $past(event_req) && event_req |-> $stable(fields))
    else begin
      $error("event fields changed while event_req was high");
      fail_count = fail_count + 1;
    end

  // no new request until the previous ack is gone
  no_rise_on_ack: assert property (@(posedge clock) disable iff (reset)
    !event_req && event_ack |=> !event_req)
    else begin
      $error("event_req rose while event_ack was high");
      fail_count = fail_count + 1;
    end

  idle_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !event_req)
    else begin
      $error("event_req high in the cycle after reset");
      fail_count = fail_count + 1;
    end

endmodule

// ==== hdl/commit_trace_unit.sv ====
// commit trace unit top, two trackers feeding one handshake arbiter
`timescale 1ns/100ps

module commit_trace_unit #(
  parameter int fifo_depth = 4,
  parameter logic [trace_pkg::xlen-trace_pkg::mmio_page_lsb-1:0] mmio_page = 'h200
) (
  input  logic                             clock,
  input  logic                             reset,
  // writeback side
  input  logic                             wb_commit,
  input  logic [trace_pkg::xlen-1:0]       wb_pc,
  input  logic [trace_pkg::inst_w-1:0]     wb_inst,
  input  logic                             wb_rd_ena,
  input  logic [trace_pkg::reg_addr_w-1:0] wb_rd_addr,
  input  logic [trace_pkg::xlen-1:0]       wb_rd_data,
  input  logic                             wb_skip,
  input  logic                             wb_store_ena,
  input  logic [trace_pkg::xlen-1:0]       wb_store_addr,
  input  logic [trace_pkg::xlen-1:0]       wb_store_data,
  input  logic [trace_pkg::mask_w-1:0]     wb_store_mask,
  // event port
  input  logic                             event_ack,
  output logic                             event_req,
  output trace_pkg::event_kind_e           event_kind,
  output logic [trace_pkg::xlen-1:0]       event_pc,
  output logic [trace_pkg::inst_w-1:0]     event_inst,
  output logic                             event_rd_ena,
  output logic [trace_pkg::reg_addr_w-1:0] event_rd_addr,
  output logic [trace_pkg::xlen-1:0]       event_data,
  output logic [trace_pkg::xlen-1:0]       event_addr,
  output logic [trace_pkg::mask_w-1:0]     event_mask,
  output logic                             event_skip,
  output logic                             overflow
);

  // commit stream
  logic                             commit_valid;
  trace_pkg::event_kind_e           commit_kind;
  logic [trace_pkg::xlen-1:0]       commit_pc;
  logic [trace_pkg::inst_w-1:0]     commit_inst;
  logic                             commit_rd_ena;
  logic [trace_pkg::reg_addr_w-1:0] commit_rd_addr;
  logic [trace_pkg::xlen-1:0]       commit_data;
  logic [trace_pkg::xlen-1:0]       commit_addr;
  logic                             commit_skip;
  logic                             commit_lost;
  logic                             commit_pop;
  // store stream
  logic                             store_valid;
  logic [trace_pkg::xlen-1:0]       store_addr;
  logic [trace_pkg::xlen-1:0]       store_data;
  logic [trace_pkg::mask_w-1:0]     store_mask;
  logic                             store_lost;
  logic                             store_pop;

  commit_tracker #(
    .fifo_depth (fifo_depth)
  ) u_commit_tracker (
    .clock        (clock),
    .reset        (reset),
    .wb_commit    (wb_commit),
    .wb_pc        (wb_pc),
    .wb_inst      (wb_inst),
    .wb_rd_ena    (wb_rd_ena),
    .wb_rd_addr   (wb_rd_addr),
    .wb_rd_data   (wb_rd_data),
    .wb_skip      (wb_skip),
    .pop          (commit_pop),
    .head_valid   (commit_valid),
    .head_kind    (commit_kind),
    .head_pc      (commit_pc),
    .head_inst    (commit_inst),
    .head_rd_ena  (commit_rd_ena),
    .head_rd_addr (commit_rd_addr),
    .head_data    (commit_data),
    .head_addr    (commit_addr),
    .head_skip    (commit_skip),
    .lost         (commit_lost)
  );

  store_tracker #(
    .fifo_depth (fifo_depth),
    .mmio_page  (mmio_page)
  ) u_store_tracker (
    .clock         (clock),
    .reset         (reset),
    .wb_commit     (wb_commit),
    .wb_store_ena  (wb_store_ena),
    .wb_store_addr (wb_store_addr),
    .wb_store_data (wb_store_data),
    .wb_store_mask (wb_store_mask),
    .pop           (store_pop),
    .head_valid    (store_valid),
    .head_addr     (store_addr),
    .head_data     (store_data),
    .head_mask     (store_mask),
    .lost          (store_lost)
  );

  event_arbiter u_event_arbiter (
    .clock          (clock),
    .reset          (reset),
    .commit_valid   (commit_valid),
    .commit_kind    (commit_kind),
    .commit_pc      (commit_pc),
    .commit_inst    (commit_inst),
    .commit_rd_ena  (commit_rd_ena),
    .commit_rd_addr (commit_rd_addr),
    .commit_data    (commit_data),
    .commit_addr    (commit_addr),
    .commit_skip    (commit_skip),
    .commit_lost    (commit_lost),
    .commit_pop     (commit_pop),
    .store_valid    (store_valid),
    .store_addr     (store_addr),
    .store_data     (store_data),
    .store_mask     (store_mask),
    .store_lost     (store_lost),
    .store_pop      (store_pop),
    .event_ack      (event_ack),
    .event_req      (event_req),
    .event_kind     (event_kind),
    .event_pc       (event_pc),
    .event_inst     (event_inst),
    .event_rd_ena   (event_rd_ena),
    .event_rd_addr  (event_rd_addr),
    .event_data     (event_data),
    .event_addr     (event_addr),
    .event_mask     (event_mask),
    .event_skip     (event_skip),
    .overflow       (overflow)
  );

endmodule

// ==== hdl/event_arbiter.sv ====
// event arbiter, round-robin merge of both record streams onto a four-phase port
`timescale 1ns/100ps

module event_arbiter (
  input  logic                             clock,
  input  logic                             reset,
  // commit stream
  input  logic                             commit_valid,
  input  trace_pkg::event_kind_e           commit_kind,
  input  logic [trace_pkg::xlen-1:0]       commit_pc,
  input  logic [trace_pkg::inst_w-1:0]     commit_inst,
  input  logic                             commit_rd_ena,
  input  logic [trace_pkg::reg_addr_w-1:0] commit_rd_addr,
  input  logic [trace_pkg::xlen-1:0]       commit_data,
  input  logic [trace_pkg::xlen-1:0]       commit_addr,
  input  logic                             commit_skip,
  input  logic                             commit_lost,
  output logic                             commit_pop,
  // store stream
  input  logic                             store_valid,
  input  logic [trace_pkg::xlen-1:0]       store_addr,
  input  logic [trace_pkg::xlen-1:0]       store_data,
  input  logic [trace_pkg::mask_w-1:0]     store_mask,
  input  logic                             store_lost,
  output logic                             store_pop,
  // output port
  input  logic                             event_ack,
  output logic                             event_req,
  output trace_pkg::event_kind_e           event_kind,
  output logic [trace_pkg::xlen-1:0]       event_pc,
  output logic [trace_pkg::inst_w-1:0]     event_inst,
  output logic                             event_rd_ena,
  output logic [trace_pkg::reg_addr_w-1:0] event_rd_addr,
  output logic [trace_pkg::xlen-1:0]       event_data,
  output logic [trace_pkg::xlen-1:0]       event_addr,
  output logic [trace_pkg::mask_w-1:0]     event_mask,
  output logic                             event_skip,
  output logic                             overflow
);

  trace_pkg::hs_state_e state;
  logic                 last_store;
  logic                 grant_commit;
  logic                 grant_store;

  // when both wait, serve the one that lost last time
  assign grant_store  = store_valid & (~commit_valid | ~last_store);
  assign grant_commit = commit_valid & ~grant_store;

  // pop only when a new event is launched
  assign commit_pop = (state == trace_pkg::hs_idle) & grant_commit;
  assign store_pop  = (state == trace_pkg::hs_idle) & grant_store;

  assign event_req = (state == trace_pkg::hs_req);

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= trace_pkg::hs_idle;
      last_store <= 1'b0;
    end else begin
      case (state)
        trace_pkg::hs_idle: begin
          if (grant_commit || grant_store) begin
            state      <= trace_pkg::hs_req;
            last_store <= grant_store;
          end
        end
        trace_pkg::hs_req: begin
          if (event_ack) begin
            state <= trace_pkg::hs_release;
          end
        end
        trace_pkg::hs_release: begin
          // wait for ack to drop before the next request
          if (!event_ack) begin
            state <= trace_pkg::hs_idle;
          end
        end
        default: state <= trace_pkg::hs_idle;
      endcase
    end
  end

  // output fields load with the pop and hold through the handshake
  always_ff @(posedge clock) begin
    if (commit_pop) begin
      event_kind    <= commit_kind;
      event_pc      <= commit_pc;
      event_inst    <= commit_inst;
      event_rd_ena  <= commit_rd_ena;
      event_rd_addr <= commit_rd_addr;
      event_data    <= commit_data;
      event_addr    <= commit_addr;
      event_mask    <= '0;
      event_skip    <= commit_skip;
    end else if (store_pop) begin
      event_kind    <= trace_pkg::kind_store;
      event_pc      <= '0;
      event_inst    <= '0;
      event_rd_ena  <= 1'b0;
      event_rd_addr <= '0;
      event_data    <= store_data;
      event_addr    <= store_addr;
      event_mask    <= store_mask;
      event_skip    <= 1'b0;
    end
  end

  // sticky until reset
  always_ff @(posedge clock) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (commit_lost || store_lost) begin
      overflow <= 1'b1;
    end
  end

endmodule

// ==== hdl/store_tracker.sv ====
// store tracker, queues retired stores that fall outside the mmio page
`timescale 1ns/100ps

module store_tracker #(
  parameter int fifo_depth = 4,
  parameter logic [trace_pkg::xlen-trace_pkg::mmio_page_lsb-1:0] mmio_page = 'h200
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            wb_commit,
  input  logic                            wb_store_ena,
  input  logic [trace_pkg::xlen-1:0]      wb_store_addr,
  input  logic [trace_pkg::xlen-1:0]      wb_store_data,
  input  logic [trace_pkg::mask_w-1:0]    wb_store_mask,
  input  logic                            pop,
  output logic                            head_valid,
  output logic [trace_pkg::xlen-1:0]      head_addr,
  output logic [trace_pkg::xlen-1:0]      head_data,
  output logic [trace_pkg::mask_w-1:0]    head_mask,
  output logic                            lost
);

  localparam int rec_w = trace_pkg::store_rec_w;

  logic             in_page;
  logic             push;
  logic [rec_w-1:0] push_rec;
  logic [rec_w-1:0] head_rec;
  logic             full;

  // device accesses are not part of the memory trace
  assign in_page = (wb_store_addr[trace_pkg::xlen-1:trace_pkg::mmio_page_lsb] == mmio_page);
  assign push    = wb_commit & wb_store_ena & ~in_page;

  assign push_rec = {wb_store_addr, wb_store_data, wb_store_mask};

  record_fifo #(
    .width      (rec_w),
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (push),
    .push_data (push_rec),
    .pop       (pop),
    .head      (head_rec),
    .not_empty (head_valid),
    .full      (full)
  );

  assign {head_addr, head_data, head_mask} = head_rec;

  assign lost = push & full;

endmodule

// ==== hdl/commit_tracker.sv ====
// commit tracker, queues retired instructions and stamps traps with the counters
`timescale 1ns/100ps

module commit_tracker #(
  parameter int fifo_depth = 4
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                wb_commit,
  input  logic [trace_pkg::xlen-1:0]          wb_pc,
  input  logic [trace_pkg::inst_w-1:0]        wb_inst,
  input  logic                                wb_rd_ena,
  input  logic [trace_pkg::reg_addr_w-1:0]    wb_rd_addr,
  input  logic [trace_pkg::xlen-1:0]          wb_rd_data,
  input  logic                                wb_skip,
  input  logic                                pop,
  output logic                                head_valid,
  output trace_pkg::event_kind_e              head_kind,
  output logic [trace_pkg::xlen-1:0]          head_pc,
  output logic [trace_pkg::inst_w-1:0]        head_inst,
  output logic                                head_rd_ena,
  output logic [trace_pkg::reg_addr_w-1:0]    head_rd_addr,
  output logic [trace_pkg::xlen-1:0]          head_data,
  output logic [trace_pkg::xlen-1:0]          head_addr,
  output logic                                head_skip,
  output logic                                lost
);

  localparam int rec_w = trace_pkg::commit_rec_w;

  logic [trace_pkg::xlen-1:0] cycle_count;
  logic [trace_pkg::xlen-1:0] instr_count;
  logic                       is_trap;
  logic [trace_pkg::xlen-1:0] rec_data;
  logic [trace_pkg::xlen-1:0] rec_addr;
  logic [rec_w-1:0]           push_rec;
  logic [rec_w-1:0]           head_rec;
  logic                       full;

  // free running cycle count, instruction count per commit
  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= '0;
      instr_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;
      if (wb_commit) begin
        instr_count <= instr_count + 1'b1;
      end
    end
  end

  assign is_trap = (wb_inst[6:0] == trace_pkg::opcode_trap);

  // trap records carry the count including the trap itself
  assign rec_data = is_trap ? instr_count + 1'b1 : wb_rd_data;
  assign rec_addr = is_trap ? cycle_count : '0;

  assign push_rec = {wb_pc, wb_inst, wb_rd_ena, wb_rd_addr, rec_data, rec_addr, wb_skip};

  record_fifo #(
    .width      (rec_w),
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (wb_commit),
    .push_data (push_rec),
    .pop       (pop),
    .head      (head_rec),
    .not_empty (head_valid),
    .full      (full)
  );

  assign {head_pc, head_inst, head_rd_ena, head_rd_addr, head_data, head_addr, head_skip} =
    head_rec;

  // kind follows from the stored opcode
  assign head_kind = (head_inst[6:0] == trace_pkg::opcode_trap) ?
                     trace_pkg::kind_trap : trace_pkg::kind_commit;

  assign lost = wb_commit & full;

endmodule

// ==== hdl/record_fifo.sv ====
// record fifo, a small synchronous circular queue of packed records
`timescale 1ns/100ps

module record_fifo #(
  parameter int width      = 8,
  parameter int fifo_depth = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             push,
  input  logic [width-1:0] push_data,
  input  logic             pop,
  output logic [width-1:0] head,
  output logic             not_empty,
  output logic             full
);

  localparam int ptr_w   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int count_w = $clog2(fifo_depth + 1);

  logic [width-1:0]   mem [fifo_depth];
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [count_w-1:0] count;
  logic               do_push;
  logic               do_pop;

  // pointer wrap for depths that are not a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = (count == count_w'(fifo_depth));
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  // push into a full queue is dropped here, the owner flags it
  assign do_push = push & ~full;
  assign do_pop  = pop & not_empty;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/trace_pkg.sv ====
// commit trace package with widths, record sizes and the shared enums
package trace_pkg;

  // datapath widths
  localparam int xlen       = 64;
  localparam int inst_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int mask_w     = 8;

  // address bits from here upward select the mmio page
  localparam int mmio_page_lsb = 16;

  // opcodes the tracer cares about
  typedef enum logic [6:0] {
    opcode_trap = 7'h6b
  } opcode_e;

  // pc, inst, rd enable, rd index, data, cycle stamp, skip
  // the cycle stamp is only nonzero for trap records
  localparam int commit_rec_w = xlen + inst_w + 1 + reg_addr_w + xlen + xlen + 1;

  // address, data, byte mask
  localparam int store_rec_w = xlen + xlen + mask_w;

  // kind of event on the output port
  typedef enum logic [1:0] {
    kind_commit = 2'd0,
    kind_trap   = 2'd1,
    kind_store  = 2'd2
  } event_kind_e;

  // four-phase output handshake
  typedef enum logic [1:0] {
    hs_idle    = 2'd0,
    hs_req     = 2'd1,
    hs_release = 2'd2
  } hs_state_e;

endpackage
